//--- rtl/sbs_pkg.sv
package sbs_pkg;

    // sizes
    localparam int WORD_W      = 16;
    localparam int N_OUT       = 4;
    localparam int N_PRIO      = 4;
    localparam int N_QUEUES    = N_OUT * N_PRIO;
    localparam int PAGE_WORDS  = 8;
    localparam int N_PAGES     = 64;
    localparam int MAX_LEN     = 63;
    localparam int FULL_PAGES  = 8;
    localparam int CREDIT_INIT = 4;

    // derived field widths
    localparam int DEST_W  = $clog2(N_OUT);
    localparam int PRIO_W  = $clog2(N_PRIO);
    localparam int PAGE_W  = $clog2(N_PAGES);
    localparam int OFFS_W  = $clog2(PAGE_WORDS);
    localparam int QID_W   = $clog2(N_QUEUES);
    localparam int LEN_W   = $clog2(MAX_LEN + 1);
    localparam int SPARE_W = WORD_W - DEST_W - PRIO_W - LEN_W;

    typedef logic [PAGE_W-1:0]             page_t;
    typedef logic [OFFS_W-1:0]             offs_t;
    typedef logic [QID_W-1:0]              qid_t;
    typedef logic [$clog2(N_PAGES+1)-1:0]  pcount_t;
    typedef logic [$clog2(CREDIT_INIT+1):0] credit_t;

    // first word of every packet
    typedef struct packed {
        logic [DEST_W-1:0]  dest;
        logic [PRIO_W-1:0]  prio;
        logic [SPARE_W-1:0] spare;
        logic [LEN_W-1:0]   len;
    } hdr_t;

    typedef union packed {
        hdr_t              hdr;
        logic [WORD_W-1:0] raw;
    } word_u;

    typedef struct packed {
        logic              vld;
        logic              sop;
        logic              eop;
        logic [WORD_W-1:0] data;
    } in_flit_t;

    typedef struct packed {
        logic              vld;
        logic              sop;
        logic              eop;
        logic [WORD_W-1:0] data;
    } out_flit_t;

    typedef struct packed {
        logic              en;
        page_t             page;
        offs_t             offs;
        logic [WORD_W-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic  en;
        page_t page;
        page_t next;
    } link_wr_t;

    // one finished packet, head and tail page
    typedef struct packed {
        logic  en;
        qid_t  qid;
        page_t head;
        page_t tail;
    } enq_t;

    typedef struct packed {
        logic  en;
        page_t page;
        offs_t offs;
    } rd_req_t;

endpackage

//--- rtl/ingress_writer.sv
`timescale 1ns/10ps

module ingress_writer (
    input  logic              clk,
    input  logic              rst_n,
    input  sbs_pkg::in_flit_t in,
    input  sbs_pkg::page_t    alloc_page,
    input  sbs_pkg::pcount_t  free_count,
    output logic              full,
    output sbs_pkg::mem_wr_t  mem_wr,
    output sbs_pkg::link_wr_t link_wr,
    output logic              alloc,
    output sbs_pkg::enq_t     enq
);
    import sbs_pkg::*;

    word_u in_word;
    page_t cur_page;
    page_t head_page;
    page_t wr_page;
    offs_t offs;
    offs_t wr_offs;
    qid_t  qid;
    logic  page_end;
    logic  last_wr;

    assign in_word.raw = in.data;

    // offset wrapped, so this word opens a fresh page
    assign page_end = !in.sop && offs == '0;
    assign alloc    = in.vld && (in.sop || page_end);
    assign wr_page  = alloc ? alloc_page : cur_page;
    assign wr_offs  = in.sop ? '0 : offs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wr.en  <= 1'b0;
            link_wr.en <= 1'b0;
            enq.en     <= 1'b0;
            last_wr    <= 1'b0;
            full       <= 1'b0;
            offs       <= '0;
        end else begin
            mem_wr.en  <= in.vld;
            link_wr.en <= in.vld && page_end;
            last_wr    <= in.vld && in.eop;
            // enqueue once the last word has landed
            enq.en     <= last_wr;
            // free space left after this cycle's allocate
            full       <= int'(free_count) < FULL_PAGES + int'(alloc);
            if (in.vld) begin
                offs <= wr_offs + 1'b1;
            end
        end
    end

    // word and link payload
    always_ff @(posedge clk) begin
        mem_wr.page  <= wr_page;
        mem_wr.offs  <= wr_offs;
        mem_wr.data  <= in.data;
        link_wr.page <= cur_page;
        link_wr.next <= alloc_page;
        if (in.vld) begin
            cur_page <= wr_page;
        end
    end

    // header decode on sop
    always_ff @(posedge clk) begin
        if (in.vld && in.sop) begin
            head_page <= alloc_page;
            qid       <= {in_word.hdr.dest, in_word.hdr.prio};
        end
    end

    // sampled while last_wr is high, before a new sop can move them
    always_ff @(posedge clk) begin
        enq.qid  <= qid;
        enq.head <= head_page;
        enq.tail <= cur_page;
    end

endmodule

//--- rtl/egress_reader.sv
`timescale 1ns/10ps

module egress_reader (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [sbs_pkg::N_OUT-1:0]               credit_ret,
    input  logic [sbs_pkg::N_QUEUES-1:0]            q_nonempty,
    input  sbs_pkg::page_t [sbs_pkg::N_QUEUES-1:0]  q_head,
    input  sbs_pkg::word_u                          rd_data,
    input  sbs_pkg::page_t                          rd_next,
    output sbs_pkg::out_flit_t [sbs_pkg::N_OUT-1:0] out,
    output sbs_pkg::rd_req_t                        rd_req,
    output logic                                    deq,
    output sbs_pkg::qid_t                           deq_qid,
    output logic                                    release_en,
    output sbs_pkg::page_t                          release_page
);
    import sbs_pkg::*;

    credit_t            credit [N_OUT];
    logic [N_OUT-1:0]   port_ready;
    logic               pick_vld;
    logic [DEST_W-1:0]  pick_port;
    logic [PRIO_W-1:0]  pick_prio;
    logic [DEST_W-1:0]  rr_port;

    logic               busy;
    logic [DEST_W-1:0]  port_q;
    qid_t               qid_q;
    page_t              cur_page;
    page_t              nxt_q;
    logic [LEN_W-1:0]   idx;
    logic [LEN_W-1:0]   len_q;

    logic               issue;
    logic               is_last;
    logic               page_start;
    logic [LEN_W-1:0]   eff_len;
    page_t              eff_next;
    page_t              rd_page;

    // read in flight, data arrives next cycle
    logic               s1_vld;
    logic [DEST_W-1:0]  s1_port;
    logic               s1_sop;
    logic               s1_eop;

    always_comb begin
        for (int k = 0; k < N_OUT; k++) begin
            port_ready[k] = |q_nonempty[k*N_PRIO +: N_PRIO] && credit[k] != '0;
        end
    end

    // round robin across outputs, strict priority inside one
    always_comb begin
        pick_vld  = 1'b0;
        pick_port = rr_port;
        for (int i = N_OUT; i > 0; i--) begin
            if (port_ready[DEST_W'(rr_port + i)]) begin
                pick_vld  = 1'b1;
                pick_port = DEST_W'(rr_port + i);
            end
        end
        pick_prio = '0;
        for (int j = N_PRIO - 1; j >= 0; j--) begin
            if (q_nonempty[{pick_port, PRIO_W'(j)}]) begin
                pick_prio = PRIO_W'(j);
            end
        end
    end

    // header comes back the cycle after word 0 is read
    assign eff_len    = (s1_vld && s1_sop) ? rd_data.hdr.len : len_q;
    assign eff_next   = s1_vld ? rd_next : nxt_q;
    assign page_start = idx[OFFS_W-1:0] == '0 && idx != '0;
    assign rd_page    = page_start ? eff_next : cur_page;
    assign is_last    = idx != '0 && idx == eff_len;
    assign issue      = busy && credit[port_q] != '0;

    assign rd_req       = '{en: issue, page: rd_page, offs: idx[OFFS_W-1:0]};
    assign release_en   = issue && (idx[OFFS_W-1:0] == '1 || is_last);
    assign release_page = rd_page;
    assign deq          = issue && is_last;
    assign deq_qid      = qid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            rr_port <= '1;
            s1_vld  <= 1'b0;
            out     <= '0;
            for (int k = 0; k < N_OUT; k++) begin
                credit[k] <= credit_t'(CREDIT_INIT);
            end
        end else begin
            if (issue && is_last) begin
                busy <= 1'b0;
            end else if (!busy && pick_vld) begin
                busy    <= 1'b1;
                rr_port <= pick_port;
            end
            s1_vld <= issue;
            for (int k = 0; k < N_OUT; k++) begin
                credit[k] <= credit[k] + credit_t'(credit_ret[k])
                             - credit_t'(issue && port_q == DEST_W'(k));
                out[k].vld  <= s1_vld && s1_port == DEST_W'(k);
                out[k].sop  <= s1_vld && s1_port == DEST_W'(k) && s1_sop;
                out[k].eop  <= s1_vld && s1_port == DEST_W'(k) && s1_eop;
                out[k].data <= rd_data.raw;
            end
        end
    end

    // packet walk state
    always_ff @(posedge clk) begin
        if (!busy) begin
            port_q   <= pick_port;
            qid_q    <= {pick_port, pick_prio};
            cur_page <= q_head[{pick_port, pick_prio}];
            idx      <= '0;
        end else if (issue) begin
            idx      <= idx + 1'b1;
            cur_page <= rd_page;
        end
        s1_port <= port_q;
        s1_sop  <= idx == '0;
        s1_eop  <= is_last;
        if (s1_vld && s1_sop) begin
            len_q <= rd_data.hdr.len;
        end
        if (s1_vld) begin
            nxt_q <= rd_next;
        end
    end

endmodule

//--- rtl/page_store.sv
`timescale 1ns/10ps

module page_store (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  sbs_pkg::mem_wr_t                       mem_wr,
    input  sbs_pkg::link_wr_t                      link_wr,
    input  logic                                   alloc,
    input  sbs_pkg::enq_t                          enq,
    input  sbs_pkg::rd_req_t                       rd_req,
    input  logic                                   deq,
    input  sbs_pkg::qid_t                          deq_qid,
    input  logic                                   release_en,
    input  sbs_pkg::page_t                         release_page,
    output sbs_pkg::page_t                         alloc_page,
    output sbs_pkg::pcount_t                       free_count,
    output sbs_pkg::word_u                         rd_data,
    output sbs_pkg::page_t                         rd_next,
    output logic [sbs_pkg::N_QUEUES-1:0]           q_nonempty,
    output sbs_pkg::page_t [sbs_pkg::N_QUEUES-1:0] q_head
);
    import sbs_pkg::*;

    logic [WORD_W-1:0]   mem [N_PAGES*PAGE_WORDS];
    page_t               link [N_PAGES];
    logic [N_PAGES-1:0]  free_map;
    pcount_t             q_count [N_QUEUES];
    page_t               q_tail [N_QUEUES];
    logic [N_QUEUES-1:0] enq_hit;
    logic [N_QUEUES-1:0] deq_hit;
    logic                tail_link;
    page_t               deq_next;

    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            mem[{mem_wr.page, mem_wr.offs}] <= mem_wr.data;
        end
        if (rd_req.en) begin
            rd_data.raw <= mem[{rd_req.page, rd_req.offs}];
            rd_next     <= link[rd_req.page];
        end
    end

    // old tail points at the new packet's head
    assign tail_link = enq.en && q_count[enq.qid] != '0;

    // dequeue arrives together with the release of the packet's last page
    assign deq_next = link[release_page];

    // jump table, page chain and packet chain share it
    always_ff @(posedge clk) begin
        if (link_wr.en) begin
            link[link_wr.page] <= link_wr.next;
        end
        if (tail_link) begin
            link[q_tail[enq.qid]] <= enq.head;
        end
    end

    // lowest free page
    always_comb begin
        alloc_page = '0;
        for (int i = N_PAGES - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_page = page_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map   <= '1;
            free_count <= pcount_t'(N_PAGES);
        end else begin
            if (alloc) begin
                free_map[alloc_page] <= 1'b0;
            end
            if (release_en) begin
                free_map[release_page] <= 1'b1;
            end
            free_count <= free_count - pcount_t'(alloc) + pcount_t'(release_en);
        end
    end

    always_comb begin
        for (int q = 0; q < N_QUEUES; q++) begin
            enq_hit[q]    = enq.en && enq.qid == qid_t'(q);
            deq_hit[q]    = deq && deq_qid == qid_t'(q);
            q_nonempty[q] = q_count[q] != '0;
        end
    end

    // packets per queue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < N_QUEUES; q++) begin
                q_count[q] <= '0;
            end
        end else begin
            for (int q = 0; q < N_QUEUES; q++) begin
                q_count[q] <= q_count[q] + pcount_t'(enq_hit[q]) - pcount_t'(deq_hit[q]);
            end
        end
    end

    // head and tail pages
    always_ff @(posedge clk) begin
        for (int q = 0; q < N_QUEUES; q++) begin
            if (enq_hit[q]) begin
                q_tail[q] <= enq.tail;
            end
            // queue empty, or its only packet leaves in this cycle
            if (enq_hit[q] && (q_count[q] == '0 ||
                               (deq_hit[q] && q_count[q] == pcount_t'(1)))) begin
                q_head[q] <= enq.head;
            end else if (deq_hit[q] && q_count[q] > pcount_t'(1)) begin
                q_head[q] <= deq_next;
            end
        end
    end

endmodule

//--- rtl/shared_buffer_switch.sv
`timescale 1ns/10ps

module shared_buffer_switch (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  sbs_pkg::in_flit_t                       in,
    input  logic [sbs_pkg::N_OUT-1:0]               credit_ret,
    output logic                                    full,
    output sbs_pkg::out_flit_t [sbs_pkg::N_OUT-1:0] out
);
    import sbs_pkg::*;

    mem_wr_t             mem_wr;
    link_wr_t            link_wr;
    enq_t                enq;
    rd_req_t             rd_req;
    logic                alloc;
    logic                deq;
    logic                release_en;
    qid_t                deq_qid;
    page_t               alloc_page;
    page_t               release_page;
    page_t               rd_next;
    pcount_t             free_count;
    word_u               rd_data;
    logic [N_QUEUES-1:0] q_nonempty;
    page_t [N_QUEUES-1:0] q_head;

    ingress_writer ingress_writer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (in),
        .alloc_page (alloc_page),
        .free_count (free_count),
        .full       (full),
        .mem_wr     (mem_wr),
        .link_wr    (link_wr),
        .alloc      (alloc),
        .enq        (enq)
    );

    egress_reader egress_reader_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .credit_ret   (credit_ret),
        .q_nonempty   (q_nonempty),
        .q_head       (q_head),
        .rd_data      (rd_data),
        .rd_next      (rd_next),
        .out          (out),
        .rd_req       (rd_req),
        .deq          (deq),
        .deq_qid      (deq_qid),
        .release_en   (release_en),
        .release_page (release_page)
    );

    page_store page_store_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_wr       (mem_wr),
        .link_wr      (link_wr),
        .alloc        (alloc),
        .enq          (enq),
        .rd_req       (rd_req),
        .deq          (deq),
        .deq_qid      (deq_qid),
        .release_en   (release_en),
        .release_page (release_page),
        .alloc_page   (alloc_page),
        .free_count   (free_count),
        .rd_data      (rd_data),
        .rd_next      (rd_next),
        .q_nonempty   (q_nonempty),
        .q_head       (q_head)
    );

endmodule

//--- sim/tb_shared_buffer_switch.sv
`timescale 1ns/10ps

module tb_shared_buffer_switch;
    import sbs_pkg::*;

    localparam int EXP_DEPTH = 1024;

    logic                  clk;
    logic                  rst_n;
    in_flit_t              in;
    logic [N_OUT-1:0]      credit_ret;
    logic                  full;
    out_flit_t [N_OUT-1:0] out;

    // expected words per output, ring buffers
    out_flit_t exp_mem [N_OUT][EXP_DEPTH];
    int        exp_wr [N_OUT];
    int        exp_rd [N_OUT];
    // packets held back until their output order is known
    out_flit_t held [4][MAX_LEN+1];
    int        held_len [4];
    int        held_dest [4];

    int               rx_count [N_OUT];
    int               ret_count [N_OUT];
    int               ret_pending [N_OUT];
    logic [N_OUT-1:0] ret_en;
    int               words_in;
    int               cycles;
    int               mismatch_count;
    int               error_count;
    logic [31:0]      lcg_state;

    shared_buffer_switch shared_buffer_switch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (in),
        .credit_ret (credit_ret),
        .full       (full),
        .out        (out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_flit(input int port, input out_flit_t got, input out_flit_t exp);
        if (got !== exp) begin
            $display("MISMATCH out[%0d] got %h expected %h", port, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic compare_full(input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH full got %h expected %h", got, exp);
            mismatch_count++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic push_word(input int dest, input out_flit_t f);
        exp_mem[dest][exp_wr[dest] % EXP_DEPTH] = f;
        exp_wr[dest]++;
    endtask

    task automatic push_held(input int slot);
        for (int i = 0; i <= held_len[slot]; i++) begin
            push_word(held_dest[slot], held[slot][i]);
        end
    endtask

    // slot below zero goes straight to the reference queue
    task automatic send_packet(input int dest, input int prio, input int len,
                               input bit gaps, input int slot);
        word_u       hw;
        in_flit_t    f;
        out_flit_t   pkt [MAX_LEN+1];
        logic [31:0] r;
        hw.hdr.dest  = DEST_W'(dest);
        hw.hdr.prio  = PRIO_W'(prio);
        hw.hdr.spare = '0;
        hw.hdr.len   = LEN_W'(len);
        for (int i = 0; i <= len; i++) begin
            r      = next_rand();
            f.vld  = 1'b1;
            f.sop  = i == 0;
            f.eop  = i == len;
            f.data = (i == 0) ? hw.raw : r[WORD_W-1:0];
            pkt[i] = out_flit_t'(f);
            @(posedge clk);
            if (gaps && r[31:29] == 3'd0) begin
                in <= '0;
                @(posedge clk);
            end
            // a new packet waits for buffer space
            while (i == 0 && full) begin
                @(posedge clk);
            end
            in <= f;
            words_in++;
        end
        @(posedge clk);
        in <= '0;
        for (int i = 0; i <= len; i++) begin
            if (slot < 0) begin
                push_word(dest, pkt[i]);
            end else begin
                held[slot][i] = pkt[i];
            end
        end
        if (slot >= 0) begin
            held_len[slot]  = len;
            held_dest[slot] = dest;
        end
    endtask

    task automatic wait_drained();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = 1'b0;
            for (int k = 0; k < N_OUT; k++) begin
                if (exp_rd[k] != exp_wr[k] || ret_pending[k] != 0) begin
                    busy = 1'b1;
                end
            end
        end
        repeat (4) @(posedge clk);
    endtask

    // sink side: check each word and hand its credit back
    always @(posedge clk) begin
        if (rst_n) begin
            for (int k = 0; k < N_OUT; k++) begin
                if (out[k].vld) begin
                    if (exp_rd[k] == exp_wr[k]) begin
                        $display("ERROR: unexpected word %h on out[%0d]", out[k].data, k);
                        error_count++;
                    end else begin
                        compare_flit(k, out[k], exp_mem[k][exp_rd[k] % EXP_DEPTH]);
                        exp_rd[k]++;
                    end
                    rx_count[k]++;
                    ret_pending[k]++;
                    if (rx_count[k] > CREDIT_INIT + ret_count[k]) begin
                        $display("ERROR: out[%0d] sent %0d words on %0d returned credits",
                                 k, rx_count[k], ret_count[k]);
                        error_count++;
                    end
                end
                if (ret_en[k] && ret_pending[k] > 0) begin
                    credit_ret[k] <= 1'b1;
                    ret_pending[k]--;
                    ret_count[k]++;
                end else begin
                    credit_ret[k] <= 1'b0;
                end
            end
        end
    end

    task automatic test_pass_through();
        for (int k = 0; k < N_OUT; k++) begin
            send_packet(k, 1, 3, 1'b0, -1);
        end
        wait_drained();
    endtask

    task automatic test_multi_page();
        send_packet(0, 0, 7, 1'b0, -1);
        send_packet(0, 0, 8, 1'b0, -1);
        send_packet(0, 0, 15, 1'b0, -1);
        send_packet(0, 0, 63, 1'b0, -1);
        send_packet(3, 2, 63, 1'b1, -1);
        wait_drained();
    endtask

    task automatic test_strict_priority();
        int base;
        ret_en[2] <= 1'b0;
        base = rx_count[2];
        // one short packet spends all credits of output 2
        send_packet(2, 3, CREDIT_INIT - 1, 1'b0, -1);
        while (rx_count[2] < base + CREDIT_INIT) begin
            @(posedge clk);
        end
        send_packet(2, 3, 5, 1'b0, 0);
        send_packet(2, 1, 4, 1'b0, 1);
        send_packet(2, 0, 6, 1'b1, 2);
        send_packet(2, 1, 2, 1'b0, 3);
        repeat (10) @(posedge clk);
        compare_count("words on out[2]", rx_count[2] - base, CREDIT_INIT);
        push_held(2);
        push_held(1);
        push_held(3);
        push_held(0);
        ret_en[2] <= 1'b1;
        wait_drained();
    endtask

    task automatic test_credit_rule();
        int base;
        ret_en[1] <= 1'b0;
        base = rx_count[1];
        send_packet(1, 0, 10, 1'b0, -1);
        repeat (40) @(posedge clk);
        compare_count("words on out[1]", rx_count[1] - base, CREDIT_INIT);
        ret_en[1] <= 1'b1;
        wait_drained();
    endtask

    task automatic test_full_reuse();
        int          held_pages;
        int          n;
        logic [31:0] r;
        held_pages = 0;
        n          = 0;
        ret_en <= '0;
        @(posedge clk);
        while (!full && n < 10) begin
            compare_full(full, held_pages > N_PAGES - FULL_PAGES);
            send_packet(n % N_OUT, 0, MAX_LEN, 1'b0, -1);
            held_pages += (MAX_LEN + PAGE_WORDS) / PAGE_WORDS;
            n++;
            repeat (2) @(posedge clk);
        end
        compare_full(full, 1'b1);
        if (held_pages < N_PAGES - FULL_PAGES) begin
            $display("ERROR: full rose with only %0d pages held", held_pages);
            error_count++;
        end
        ret_en <= '1;
        wait_drained();
        compare_full(full, 1'b0);
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            send_packet(i % N_OUT, 1, 1 + int'(r[5:0]) % MAX_LEN, 1'b1, -1);
        end
        wait_drained();
    endtask

    // one priority for all, so each output keeps send order
    task automatic test_independent();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            send_packet(int'(r[9:8]), 2, 1 + int'(r[5:0]) % MAX_LEN, 1'b1, -1);
        end
        wait_drained();
    endtask

    task automatic finish_run();
        $display("mismatches: %0d, other errors: %0d", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        lcg_state  = 32'h48d0cf4f;
        rst_n      = 1'b0;
        in         = '0;
        credit_ret = '0;
        ret_en     = '1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        compare_full(full, 1'b0);
        for (int k = 0; k < N_OUT; k++) begin
            compare_flit(k, out[k], '0);
        end
        test_pass_through();
        test_multi_page();
        test_strict_priority();
        test_credit_rule();
        test_full_reuse();
        test_independent();
        finish_run();
    end

    // budget grows with the traffic sent so far
    initial begin
        cycles = 0;
        while (cycles <= 40 * words_in + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles with %0d words sent", cycles, words_in);
        error_count++;
        finish_run();
    end

endmodule

//--- shared_buffer_switch.f
rtl/sbs_pkg.sv
rtl/ingress_writer.sv
rtl/egress_reader.sv
rtl/page_store.sv
rtl/shared_buffer_switch.sv
sim/tb_shared_buffer_switch.sv
